//--- rtl/dcache_pkg.sv
// cache geometry localparams, vector typedefs, request and tag structs, controller states
`default_nettype none

package dcache_pkg;

    localparam int unsigned addr_w     = 32;
    localparam int unsigned word_w     = 32;
    localparam int unsigned line_words = 4;
    localparam int unsigned line_w     = line_words * word_w;  // 128
    localparam int unsigned offset_w   = 2;
    localparam int unsigned index_w    = 4;
    localparam int unsigned sets       = 1 << index_w;         // 16 sets
    localparam int unsigned offset_lsb = 2;                    // above the byte lane bits
    localparam int unsigned index_lsb  = offset_lsb + offset_w;
    localparam int unsigned tag_lsb    = index_lsb + index_w;
    localparam int unsigned tag_w      = addr_w - tag_lsb;     // 24

    typedef logic [addr_w-1:0]   addr_t;
    typedef logic [word_w-1:0]   word_t;
    typedef logic [line_w-1:0]   line_t;    // word 0 in the low bits
    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [index_w-1:0]  index_t;
    typedef logic [offset_w-1:0] offset_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  we;
    } cpu_req_t;

    typedef struct packed {
        addr_t addr;   // always line aligned
        logic  we;
        line_t wline;
    } mem_req_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        REFILL_WAIT
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- rtl/dcache_tag_array.sv
// two-way tag store with valid, dirty and tag per entry and one lru bit per set
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_array (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dcache_pkg::index_t     index,
    input  logic [1:0]             tag_we,
    input  dcache_pkg::tag_entry_t tag_wd,
    input  logic                   lru_we,
    input  logic                   lru_wd,
    output dcache_pkg::tag_entry_t tag0_rd,
    output dcache_pkg::tag_entry_t tag1_rd,
    output logic                   lru_rd
);

    logic [dcache_pkg::sets-1:0] valid_q [2];
    logic [dcache_pkg::sets-1:0] dirty_q [2];
    dcache_pkg::tag_t            tag_q [2][dcache_pkg::sets];
    logic [dcache_pkg::sets-1:0] lru_q;          // 1 means way 1 goes next

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            lru_q      <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (tag_we[w]) begin
                    valid_q[w][index] <= tag_wd.valid;
                end
            end
            if (lru_we) begin
                lru_q[index] <= lru_wd;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (tag_we[w]) begin
                dirty_q[w][index] <= tag_wd.dirty;
                tag_q[w][index]   <= tag_wd.tag;
            end
        end
    end

    assign tag0_rd = '{valid: valid_q[0][index],
                       dirty: dirty_q[0][index],
                       tag:   tag_q[0][index]};
    assign tag1_rd = '{valid: valid_q[1][index],
                       dirty: dirty_q[1][index],
                       tag:   tag_q[1][index]};
    assign lru_rd  = lru_q[index];

    // controller state is settled after the first reset edge
    a_no_write_in_reset: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |-> tag_we == 2'b00);

endmodule

`default_nettype wire

//--- rtl/dcache_data_array.sv
// two-way cache line storage with asynchronous read and per-way write enable
`timescale 1ns/1ns
`default_nettype none

module dcache_data_array (
    input  logic               clk,
    input  dcache_pkg::index_t index,
    input  logic [1:0]         data_we,
    input  dcache_pkg::line_t  data_wd,
    output dcache_pkg::line_t  data0_rd,
    output dcache_pkg::line_t  data1_rd
);

    // contents only meaningful where the tag valid bit is set
    dcache_pkg::line_t line_q [2][dcache_pkg::sets];

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (data_we[w]) begin
                line_q[w][index] <= data_wd;   // whole line per write
            end
        end
    end

    assign data0_rd = line_q[0][index];
    assign data1_rd = line_q[1][index];

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
// dcache controller FSM with hit check, word merge, victim choice, write-back and refill
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cpu_valid,
    input  dcache_pkg::cpu_req_t   cpu_req,
    output logic                   cpu_ready,
    output dcache_pkg::word_t      cpu_rdata,
    output dcache_pkg::index_t     index,
    input  dcache_pkg::tag_entry_t tag0_rd,
    input  dcache_pkg::tag_entry_t tag1_rd,
    input  logic                   lru_rd,
    output logic [1:0]             tag_we,
    output dcache_pkg::tag_entry_t tag_wd,
    output logic                   lru_we,
    output logic                   lru_wd,
    input  dcache_pkg::line_t      data0_rd,
    input  dcache_pkg::line_t      data1_rd,
    output logic [1:0]             data_we,
    output dcache_pkg::line_t      data_wd,
    output logic                   mem_valid,
    output dcache_pkg::mem_req_t   mem_req,
    input  logic                   mem_ack,
    input  dcache_pkg::line_t      mem_rdata
);

    dcache_pkg::ctrl_state_e state_q;
    dcache_pkg::ctrl_state_e state_d;
    dcache_pkg::cpu_req_t    req_q;        // request under service
    logic                    victim_q;     // way picked at the miss

    dcache_pkg::tag_t        req_tag;
    dcache_pkg::offset_t     req_off;
    logic                    hit0;
    logic                    hit1;
    logic                    hit;
    logic                    hit_way;
    dcache_pkg::line_t       hit_line;
    dcache_pkg::line_t       merged_line;
    logic                    victim_way;
    dcache_pkg::tag_entry_t  victim_entry;
    dcache_pkg::line_t       victim_line;
    logic                    victim_dirty;
    dcache_pkg::addr_t       wb_addr;
    dcache_pkg::addr_t       refill_addr;
    logic                    mem_done;

    // address split of the latched request
    assign req_tag = req_q.addr[dcache_pkg::tag_lsb +: dcache_pkg::tag_w];
    assign index   = req_q.addr[dcache_pkg::index_lsb +: dcache_pkg::index_w];
    assign req_off = req_q.addr[dcache_pkg::offset_lsb +: dcache_pkg::offset_w];

    assign hit0     = tag0_rd.valid && (tag0_rd.tag == req_tag);
    assign hit1     = tag1_rd.valid && (tag1_rd.tag == req_tag);
    assign hit      = hit0 || hit1;
    assign hit_way  = hit1;                            // a tag lives in one way only
    assign hit_line = hit_way ? data1_rd : data0_rd;

    assign cpu_rdata = hit_line[req_off * dcache_pkg::word_w +: dcache_pkg::word_w];

    always_comb begin
        merged_line = hit_line;
        merged_line[req_off * dcache_pkg::word_w +: dcache_pkg::word_w] = req_q.wdata;
    end

    // empty ways first, then the lru pick
    always_comb begin
        if (!tag0_rd.valid) begin
            victim_way = 1'b0;
        end else if (!tag1_rd.valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_rd;
        end
    end

    assign victim_entry = victim_way ? tag1_rd : tag0_rd;
    assign victim_line  = victim_way ? data1_rd : data0_rd;
    assign victim_dirty = victim_entry.valid && victim_entry.dirty;

    assign wb_addr     = {victim_entry.tag, index, {dcache_pkg::index_lsb{1'b0}}};
    assign refill_addr = {req_tag, index, {dcache_pkg::index_lsb{1'b0}}};
    assign mem_done    = mem_valid && mem_ack;

    always_comb begin
        state_d   = state_q;
        cpu_ready = 1'b0;
        tag_we    = 2'b00;
        tag_wd    = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
        lru_we    = 1'b0;
        lru_wd    = ~hit_way;                          // point at the other way
        data_we   = 2'b00;
        data_wd   = merged_line;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (cpu_valid) begin
                    state_d = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (hit) begin
                    cpu_ready = 1'b1;
                    lru_we    = 1'b1;
                    state_d   = dcache_pkg::IDLE;
                    if (req_q.we) begin
                        tag_we[hit_way]  = 1'b1;       // mark line dirty
                        data_we[hit_way] = 1'b1;
                    end
                end else if (victim_dirty) begin
                    state_d = dcache_pkg::WRITEBACK;
                end else begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::WRITEBACK: begin
                if (mem_done) begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                if (mem_done) begin
                    tag_we[victim_q]  = 1'b1;
                    tag_wd.dirty      = 1'b0;          // fresh line is clean
                    data_we[victim_q] = 1'b1;
                    data_wd           = mem_rdata;
                    lru_we            = 1'b1;
                    lru_wd            = ~victim_q;
                    state_d           = dcache_pkg::REFILL_WAIT;
                end
            end
            dcache_pkg::REFILL_WAIT: begin
                state_d = dcache_pkg::LOOKUP;          // retry the lookup which now hits
            end
            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= dcache_pkg::IDLE;
            mem_valid <= 1'b0;
        end else begin
            state_q <= state_d;
            case (state_q)
                dcache_pkg::LOOKUP: begin
                    if (!hit) begin
                        mem_valid <= 1'b1;
                    end
                end
                dcache_pkg::WRITEBACK: begin
                    if (mem_done) begin
                        mem_valid <= 1'b0;             // low one cycle between requests
                    end
                end
                dcache_pkg::REFILL: begin
                    mem_valid <= !mem_done;
                end
                default: begin
                    mem_valid <= 1'b0;
                end
            endcase
        end
    end

    // request, victim and memory request payload
    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::IDLE && cpu_valid) begin
            req_q <= cpu_req;
        end
        if (state_q == dcache_pkg::LOOKUP && !hit) begin
            victim_q <= victim_way;
            if (victim_dirty) begin
                mem_req <= '{addr: wb_addr, we: 1'b1, wline: victim_line};
            end else begin
                mem_req <= '{addr: refill_addr, we: 1'b0, wline: '0};
            end
        end
        if (state_q == dcache_pkg::WRITEBACK && mem_done) begin
            mem_req <= '{addr: refill_addr, we: 1'b0, wline: '0};
        end
    end

    a_mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && !mem_ack |=> mem_valid && $stable(mem_req));

    a_ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ready |-> cpu_valid);

    // at most one way written and no line cached in both ways of a set
    a_tag_single_way: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(tag_we) && (state_q != dcache_pkg::LOOKUP || !(hit0 && hit1)));

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
// dcache top level joining controller, tag array and data array
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cpu_valid,
    input  dcache_pkg::cpu_req_t cpu_req,
    output logic                 cpu_ready,
    output dcache_pkg::word_t    cpu_rdata,
    output logic                 mem_valid,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_ack,
    input  dcache_pkg::line_t    mem_rdata
);

    dcache_pkg::index_t     index;          // shared by both arrays
    dcache_pkg::tag_entry_t tag0_rd;
    dcache_pkg::tag_entry_t tag1_rd;
    logic                   lru_rd;
    logic [1:0]             tag_we;
    dcache_pkg::tag_entry_t tag_wd;
    logic                   lru_we;
    logic                   lru_wd;
    dcache_pkg::line_t      data0_rd;
    dcache_pkg::line_t      data1_rd;
    logic [1:0]             data_we;
    dcache_pkg::line_t      data_wd;

    dcache_ctrl i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .index     (index),
        .tag0_rd   (tag0_rd),
        .tag1_rd   (tag1_rd),
        .lru_rd    (lru_rd),
        .tag_we    (tag_we),
        .tag_wd    (tag_wd),
        .lru_we    (lru_we),
        .lru_wd    (lru_wd),
        .data0_rd  (data0_rd),
        .data1_rd  (data1_rd),
        .data_we   (data_we),
        .data_wd   (data_wd),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    dcache_tag_array i_tag_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .index   (index),
        .tag_we  (tag_we),
        .tag_wd  (tag_wd),
        .lru_we  (lru_we),
        .lru_wd  (lru_wd),
        .tag0_rd (tag0_rd),
        .tag1_rd (tag1_rd),
        .lru_rd  (lru_rd)
    );

    dcache_data_array i_data_array (
        .clk      (clk),
        .index    (index),
        .data_we  (data_we),
        .data_wd  (data_wd),
        .data0_rd (data0_rd),
        .data1_rd (data1_rd)
    );

endmodule

`default_nettype wire

//--- test/dcache_mem_model.sv
// next-level memory model with random ack latency, address pattern fill and alignment check
`timescale 1ns/1ns
`default_nettype none

module dcache_mem_model #(
    parameter dcache_pkg::word_t pattern_key = 32'h5a3c_96e1,
    parameter logic [31:0]       seed        = 32'h0000_0001
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mem_valid,
    input  dcache_pkg::mem_req_t mem_req,
    output logic                 mem_ack,
    output dcache_pkg::line_t    mem_rdata,
    output int                   error_count
);

    dcache_pkg::word_t store_q [dcache_pkg::addr_t];   // words changed by write-backs
    logic [31:0]       rand_q = seed;
    logic              busy   = 1'b0;
    logic [2:0]        delay  = 3'd0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic serve_request();
        dcache_pkg::addr_t a;
        dcache_pkg::line_t line;
        line = '0;
        for (int i = 0; i < 4; i++) begin
            a = mem_req.addr + dcache_pkg::addr_t'(4 * i);
            if (mem_req.we) begin
                store_q[a] = mem_req.wline[i * dcache_pkg::word_w +: dcache_pkg::word_w];
            end else if (store_q.exists(a)) begin
                line[i * dcache_pkg::word_w +: dcache_pkg::word_w] = store_q[a];
            end else begin
                line[i * dcache_pkg::word_w +: dcache_pkg::word_w] = a ^ pattern_key;
            end
        end
        mem_rdata <= line;
    endtask

    initial begin
        mem_ack     = 1'b0;
        mem_rdata   = '0;
        error_count = 0;
    end

    // ack raised on a falling edge, taken by the cache at the next rising edge
    always @(negedge clk) begin
        if (!rst_n || mem_ack) begin
            mem_ack <= 1'b0;              // one cycle pulse
            busy = 1'b0;
        end else if (mem_valid) begin
            if (!busy) begin
                busy = 1'b1;
                rand_q = xorshift32(rand_q);
                delay = rand_q[2:0];      // 1 to 8 cycles
            end
            if (delay != 3'd0) begin
                delay = delay - 3'd1;
            end else begin
                serve_request();
                mem_ack <= 1'b1;
            end
        end
    end

    a_line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid |-> mem_req.addr[3:0] == 4'h0)
    else begin
        error_count++;
        $display("FAILED at %0t: mem_req.addr is %h, expected %h", $time,
                 $sampled(mem_req.addr), $sampled(mem_req.addr) & ~32'hf);
    end

endmodule

`default_nettype wire

//--- test/dcache_tb.sv
// dcache testbench with clock, reset, random accesses, shadow memory and concurrent checks
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

    localparam int n_trans        = 400;
    localparam int timeout_cycles = (n_trans + 20) * 24;   // worst miss near 20 cycles
    localparam dcache_pkg::word_t pattern_key = 32'h5a3c_96e1;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 cpu_valid;
    dcache_pkg::cpu_req_t cpu_req;
    logic                 cpu_ready;
    dcache_pkg::word_t    cpu_rdata;
    logic                 mem_valid;
    dcache_pkg::mem_req_t mem_req;
    logic                 mem_ack;
    dcache_pkg::line_t    mem_rdata;
    int                   mem_errors;

    dcache_pkg::word_t    shadow [dcache_pkg::addr_t];    // last write per word address
    logic                 written [dcache_pkg::addr_t];   // lines dirty in the cache
    dcache_pkg::addr_t    last_line [dcache_pkg::sets];
    logic [dcache_pkg::sets-1:0] last_valid;
    logic [31:0]          rand_q = 32'hb17f6a1d;
    int                   errors = 0;
    int                   done_count = 0;
    int                   cycles = 0;
    logic                 req_seen;
    logic                 req_start;                      // first cycle of a request
    logic                 expect_hit;
    dcache_pkg::word_t    exp_rdata;
    dcache_pkg::line_t    wb_line_exp = '0;
    logic                 wb_written_exp = 1'b0;
    logic                 victim_check;
    dcache_pkg::addr_t    victim_addr;

    dcache_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    dcache_mem_model #(.pattern_key(pattern_key), .seed(32'hb17f6a1d)) i_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_valid   (mem_valid),
        .mem_req     (mem_req),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .error_count (mem_errors)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic dcache_pkg::word_t expected_word(input dcache_pkg::addr_t a);
        return shadow.exists(a) ? shadow[a] : (a ^ pattern_key);
    endfunction

    function automatic dcache_pkg::line_t expected_line(input dcache_pkg::addr_t base);
        dcache_pkg::line_t line;
        for (int i = 0; i < 4; i++) begin
            line[i * dcache_pkg::word_w +: dcache_pkg::word_w] =
                expected_word(base + dcache_pkg::addr_t'(4 * i));
        end
        return line;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        errors++;
        $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // one CPU access, entered and left on a falling edge
    task automatic run_access(input dcache_pkg::addr_t addr, input logic we,
                              input dcache_pkg::word_t wdata, input logic force_hit);
        dcache_pkg::index_t idx;
        dcache_pkg::addr_t  line_addr;
        idx        = addr[dcache_pkg::index_lsb +: dcache_pkg::index_w];
        line_addr  = addr & ~32'hf;
        exp_rdata  = expected_word(addr);
        expect_hit = force_hit || (last_valid[idx] && last_line[idx] == line_addr);
        cpu_req    = '{addr: addr, wdata: wdata, we: we};
        cpu_valid  = 1'b1;
        req_start  = 1'b1;
        req_seen   = 1'b1;
        @(negedge clk);
        req_start = 1'b0;
        while (!cpu_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        if (we) begin
            shadow[addr]       = wdata;
            written[line_addr] = 1'b1;
        end
        last_valid[idx] = 1'b1;
        last_line[idx]  = line_addr;
        done_count++;
        @(negedge clk);
        cpu_valid  = 1'b0;
        expect_hit = 1'b0;
    endtask

    // tags a, b, a then c in set 9, so b must be the victim
    task automatic check_lru_order();
        dcache_pkg::addr_t a_addr;
        dcache_pkg::addr_t b_addr;
        dcache_pkg::addr_t c_addr;
        a_addr = {24'h0a0001, 4'h9, 4'h4};
        b_addr = {24'h0a0002, 4'h9, 4'h8};
        c_addr = {24'h0a0003, 4'h9, 4'h0};
        rand_q = xorshift32(rand_q);
        run_access(a_addr, 1'b1, rand_q, 1'b0);
        rand_q = xorshift32(rand_q);
        run_access(b_addr, 1'b1, rand_q, 1'b0);
        run_access(a_addr, 1'b0, '0, 1'b1);
        victim_addr  = b_addr & ~32'hf;
        victim_check = 1'b1;
        run_access(c_addr, 1'b0, '0, 1'b0);
        victim_check = 1'b0;
        run_access(a_addr, 1'b0, '0, 1'b1);
        run_access(b_addr, 1'b0, '0, 1'b0);      // written-back data comes home
    endtask

    task automatic run_random(input int count);
        dcache_pkg::addr_t addr;
        logic              we;
        for (int n = 0; n < count; n++) begin
            rand_q = xorshift32(rand_q);
            addr   = {22'h2b5e31, rand_q[1:0], 2'b00, rand_q[3:2], rand_q[5:4], 2'b00};
            we     = rand_q[6];
            if (rand_q[7]) begin
                @(negedge clk);                   // idle gap
            end
            rand_q = xorshift32(rand_q);
            run_access(addr, we, rand_q, 1'b0);
        end
    endtask

    // memory side expectations, stable between falling edges
    always @(negedge clk) begin
        if (mem_valid) begin
            wb_line_exp    = expected_line(mem_req.addr);
            wb_written_exp = written.exists(mem_req.addr);
        end
    end

    always @(posedge clk) begin
        if (mem_valid && mem_ack && mem_req.we) begin
            written.delete(mem_req.addr);         // clean after write-back
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("timeout, no progress within %0d cycles", timeout_cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    a_reset_ready: assert property (@(posedge clk) rst_n && !req_seen |-> !cpu_ready)
        else report_mismatch("cpu_ready", 128'($sampled(cpu_ready)), 128'(0));
    a_reset_mem: assert property (@(posedge clk) rst_n && !req_seen |-> !mem_valid)
        else report_mismatch("mem_valid", 128'($sampled(mem_valid)), 128'(0));
    a_reset_state: assert property (@(posedge clk)
        rst_n && !req_seen |-> i_dut.i_ctrl.state_q == dcache_pkg::IDLE)
        else report_mismatch("state", 128'($sampled(i_dut.i_ctrl.state_q)),
                             128'(dcache_pkg::IDLE));
    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ready && !cpu_req.we |-> cpu_rdata == exp_rdata)
        else report_mismatch("cpu_rdata", 128'($sampled(cpu_rdata)),
                             128'($sampled(exp_rdata)));
    a_hit_no_mem: assert property (@(posedge clk) disable iff (!rst_n)
        expect_hit && cpu_valid |-> !mem_valid)
        else report_problem("memory request during an access that should hit");
    a_hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
        req_start && expect_hit |=> cpu_ready)
        else report_problem("hit did not finish in the second request cycle");
    a_wb_line: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && mem_ack && mem_req.we |-> mem_req.wline == wb_line_exp)
        else report_mismatch("mem_req.wline", $sampled(mem_req.wline), $sampled(wb_line_exp));
    a_wb_written: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && mem_ack && mem_req.we |-> wb_written_exp)
        else report_problem("write-back of a line that was never written");
    a_lru_victim: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && mem_ack && mem_req.we && victim_check |-> mem_req.addr == victim_addr)
        else report_mismatch("mem_req.addr", 128'($sampled(mem_req.addr)),
                             128'($sampled(victim_addr)));
    a_mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && !mem_ack |=> mem_valid && $stable(mem_req))
        else report_problem("mem_req changed or dropped before mem_ack");
    a_ready_valid: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ready |-> cpu_valid)
        else report_problem("cpu_ready raised without cpu_valid");

    initial begin
        rst_n        = 1'b0;
        cpu_valid    = 1'b0;
        cpu_req      = '0;
        req_seen     = 1'b0;
        req_start    = 1'b0;
        expect_hit   = 1'b0;
        exp_rdata    = '0;
        last_valid   = '0;
        victim_check = 1'b0;
        victim_addr  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);                // quiet window after reset
        check_lru_order();
        run_random(n_trans);
        repeat (4) @(negedge clk);
        $display("transactions %0d, check errors %0d, memory model errors %0d",
                 done_count, errors, mem_errors);
        if (errors == 0 && mem_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/dcache_pkg.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

//--- Makefile
# Verilator build and run of the dcache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)

check: run
	@grep -q '^Finished with no errors$$' $(LOG) && echo "simulation passed" \
		|| (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
